/* common/lobinho_params.svh */
`ifndef LOBINHO_PARAMS_SVH
`define LOBINHO_PARAMS_SVH

// --------------------------------------------------
// Game size
// --------------------------------------------------

// Players around the table, one wolf and one doctor among them
`define LOB_NUM_PLAYERS 5

// Deals in the ROM table: 5 wolf seats times 4 doctor seats
`define LOB_NUM_DEALS 20

// --------------------------------------------------
// Field widths
// --------------------------------------------------

// Role code width, four codes incl. the hidden one
`define LOB_ROLE_W 2

// One bit per segment a..g, no decimal point
`define LOB_SEG_W 7

`endif

/* common/game_pkg.sv */
`include "lobinho_params.svh"

package game_pkg;

    // --------------------------------------------------
    // Roles and deals
    // --------------------------------------------------

    // Role codes as shown on the role display
    typedef enum logic [`LOB_ROLE_W-1:0] {
        VILLAGER = 2'd0,
        WOLF     = 2'd1,
        DOCTOR   = 2'd2,
        HIDDEN   = 2'd3   // Also used as "nothing shown"
    } role_t;

    // Seat number, 0 .. players-1
    typedef logic [$clog2(`LOB_NUM_PLAYERS)-1:0] player_t;

    // Deal ROM address, 0 .. deals-1
    typedef logic [$clog2(`LOB_NUM_DEALS)-1:0] deal_index_t;

    // One role per seat, seat 0 in the most significant slot
    typedef role_t [0:`LOB_NUM_PLAYERS-1] deal_t;

    // --------------------------------------------------
    // Controller states
    // --------------------------------------------------

    typedef enum logic [3:0] {
        IDLE,         // Waiting for start
        CLEAR,        // Zero deal and player
        SHUFFLE,      // Deal counter spins until pass
        LOAD,         // ROM word valid, capture it
        SETTLE,       // Deal register write lands
        NIGHT_START,  // Back to player 0
        NIGHT_TURN,   // Current role on display
        NEXT_PLAYER,  // Step the seat
        HANDOVER,     // Board passed on, role hidden
        NIGHT_OVER    // Done until reset
    } game_state_t;

endpackage

/* common/display_pkg.sv */
`include "lobinho_params.svh"

package display_pkg;

    // Segment code, active low
    // Bit 6 is g, bit 0 is a
    typedef logic [`LOB_SEG_W-1:0] seg_t;

    // One hex digit for a single display
    typedef logic [3:0] hex_digit_t;

endpackage

/* common/game_ctrl_if.sv */
// Strobes from the controller to the deal datapath, status back
interface game_ctrl_if;

    logic clear_deal;    // Zero deal counter and deal register
    logic shuffle;       // Step deal counter
    logic load_deal;     // Capture ROM word
    logic clear_player;  // Zero player counter
    logic next_player;   // Step player counter
    logic show_role;     // Role output shows the seat's role
    logic last_player;   // Seat counter at last seat

    // Controller side
    modport ctrl (
        output clear_deal,
        output shuffle,
        output load_deal,
        output clear_player,
        output next_player,
        output show_role,
        input  last_player
    );

    // Datapath side
    modport dp (
        input  clear_deal,
        input  shuffle,
        input  load_deal,
        input  clear_player,
        input  next_player,
        input  show_role,
        output last_player
    );

endinterface

/* logic/mod_counter.sv */
module mod_counter #(
    parameter type count_t = logic [3:0],  // Payload, sized by the user
    parameter int  MODULUS = 10
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   clear,  // Synchronous, wins over step
    input  logic   step,
    output count_t count
);

    // Wrap value
    localparam count_t LAST = count_t'(MODULUS - 1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            if (count == LAST) begin
                count <= '0;  // Wrap around
            end else begin
                count <= count_t'(count + 1'b1);
            end
        end
    end

endmodule

/* logic/seg7_decoder.sv */
module seg7_decoder import display_pkg::*; (
    input  hex_digit_t digit,
    output seg_t       seg     // Active low, bit 6 = g
);

    //     a
    //   f   b
    //     g
    //   e   c
    //     d
    always_comb begin
        case (digit)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;  // Also the hidden role
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'ha:    seg = 7'b0001000;
            4'hb:    seg = 7'b0000011;  // Lower case b
            4'hc:    seg = 7'b1000110;
            4'hd:    seg = 7'b0100001;  // Lower case d
            4'he:    seg = 7'b0000110;
            4'hf:    seg = 7'b0001110;
            default: seg = 7'b1111111;  // Blank
        endcase
    end

endmodule

/* deal/deal_rom.sv */
module deal_rom import game_pkg::*; (
    input  logic        clock,
    input  deal_index_t index,
    output deal_t       deal    // Valid one cycle after index
);

    // Entry 4w+k: seat w is wolf, doctor is the k-th other seat upward
    // Slots left to right are seats 0..4
    always_ff @(posedge clock) begin
        case (index)
            5'd0:    deal <= deal_t'(10'b01_10_00_00_00);  // Wolf 0, doctor 1
            5'd1:    deal <= deal_t'(10'b01_00_10_00_00);  // Wolf 0, doctor 2
            5'd2:    deal <= deal_t'(10'b01_00_00_10_00);
            5'd3:    deal <= deal_t'(10'b01_00_00_00_10);
            5'd4:    deal <= deal_t'(10'b10_01_00_00_00);  // Wolf 1, doctor 0
            5'd5:    deal <= deal_t'(10'b00_01_10_00_00);
            5'd6:    deal <= deal_t'(10'b00_01_00_10_00);
            5'd7:    deal <= deal_t'(10'b00_01_00_00_10);
            5'd8:    deal <= deal_t'(10'b10_00_01_00_00);  // Wolf 2
            5'd9:    deal <= deal_t'(10'b00_10_01_00_00);
            5'd10:   deal <= deal_t'(10'b00_00_01_10_00);
            5'd11:   deal <= deal_t'(10'b00_00_01_00_10);
            5'd12:   deal <= deal_t'(10'b10_00_00_01_00);  // Wolf 3
            5'd13:   deal <= deal_t'(10'b00_10_00_01_00);
            5'd14:   deal <= deal_t'(10'b00_00_10_01_00);
            5'd15:   deal <= deal_t'(10'b00_00_00_01_10);
            5'd16:   deal <= deal_t'(10'b10_00_00_00_01);  // Wolf 4
            5'd17:   deal <= deal_t'(10'b00_10_00_00_01);
            5'd18:   deal <= deal_t'(10'b00_00_10_00_01);
            5'd19:   deal <= deal_t'(10'b00_00_00_10_01);  // Wolf 4, doctor 3
            // Unused addresses fall back to entry 0
            default: deal <= deal_t'(10'b01_10_00_00_00);
        endcase
    end

endmodule

/* deal/deal_datapath.sv */
`include "lobinho_params.svh"

module deal_datapath import game_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    game_ctrl_if.dp dp,
    output role_t   role,    // Registered, HIDDEN off turn
    output player_t player   // Current seat
);

    deal_index_t deal_index;  // Spinning ROM address
    deal_t       rom_deal;    // ROM word, one cycle behind the address
    deal_t       deal_reg;    // Deal of the running game

    // --------------------------------------------------
    // Deal selection
    // --------------------------------------------------

    mod_counter #(
        .count_t (deal_index_t),
        .MODULUS (`LOB_NUM_DEALS)
    ) deal_counter (
        .clock (clock),
        .reset (reset),
        .clear (dp.clear_deal),
        .step  (dp.shuffle),
        .count (deal_index)
    );

    deal_rom deal_table (
        .clock (clock),
        .index (deal_index),
        .deal  (rom_deal)
    );

    always_ff @(posedge clock) begin
        if (dp.clear_deal) begin
            deal_reg <= '{default: VILLAGER};
        end else if (dp.load_deal) begin
            deal_reg <= rom_deal;  // Counter already moved on, ROM still holds the pick
        end
    end

    // --------------------------------------------------
    // Seat walk
    // --------------------------------------------------

    mod_counter #(
        .count_t (player_t),
        .MODULUS (`LOB_NUM_PLAYERS)
    ) player_counter (
        .clock (clock),
        .reset (reset),
        .clear (dp.clear_player),
        .step  (dp.next_player),
        .count (player)
    );

    assign dp.last_player = (player == player_t'(`LOB_NUM_PLAYERS - 1));

    // Role mux, one cycle behind seat and show_role
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            role <= HIDDEN;
        end else if (dp.show_role) begin
            role <= deal_reg[player];
        end else begin
            role <= HIDDEN;  // Nobody else gets to see it
        end
    end

endmodule

/* game_controller/game_controller.sv */
module game_controller import game_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,       // Level, only seen in IDLE
    input  logic      pass,        // Raw button level
    game_ctrl_if.ctrl ctrl,
    output logic      night_over
);

    logic        pass_q0;     // First sample of pass
    logic        pass_q1;     // Previous sample
    logic        pass_pulse;  // One cycle per press
    game_state_t state;
    game_state_t state_next;

    // --------------------------------------------------
    // Pass edge detection
    // --------------------------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pass_q0 <= 1'b0;
            pass_q1 <= 1'b0;
        end else begin
            pass_q0 <= pass;
            pass_q1 <= pass_q0;
        end
    end

    // Rising edge only, a held button gives a single pulse
    assign pass_pulse = pass_q0 & ~pass_q1;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        state_next = state;  // Hold by default
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = CLEAR;
                end
            end
            CLEAR:       state_next = SHUFFLE;
            SHUFFLE: begin
                // Deal frozen by the press
                if (pass_pulse) begin
                    state_next = LOAD;
                end
            end
            LOAD:        state_next = SETTLE;       // ROM word captured here
            SETTLE:      state_next = NIGHT_START;  // Deal register now stable
            NIGHT_START: state_next = NIGHT_TURN;
            NIGHT_TURN: begin
                if (pass_pulse) begin
                    // Last seat ends the night
                    state_next = ctrl.last_player ? NIGHT_OVER : NEXT_PLAYER;
                end
            end
            NEXT_PLAYER: state_next = HANDOVER;
            HANDOVER: begin
                // New player ready to look
                if (pass_pulse) begin
                    state_next = NIGHT_TURN;
                end
            end
            NIGHT_OVER:  state_next = NIGHT_OVER;  // Only reset leaves
            default:     state_next = IDLE;
        endcase
    end

    // --------------------------------------------------
    // Moore outputs
    // --------------------------------------------------

    always_comb begin
        ctrl.clear_deal   = (state == IDLE) || (state == CLEAR);
        ctrl.clear_player = (state == IDLE) || (state == CLEAR) || (state == NIGHT_START);
        ctrl.shuffle      = (state == SHUFFLE);      // Counter spins every cycle
        ctrl.load_deal    = (state == LOAD);
        ctrl.next_player  = (state == NEXT_PLAYER);
        ctrl.show_role    = (state == NIGHT_TURN);   // Visible only on the turn
    end

    assign night_over = (state == NIGHT_OVER);

endmodule

/* logic/lobinho_top.sv */
module lobinho_top import game_pkg::*, display_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic start,       // Start button, active high
    input  logic pass,        // Pass button, active high
    output seg_t role_seg,
    output seg_t player_seg,
    output logic night_over
);

    role_t      role;
    player_t    player;
    hex_digit_t role_digit;    // Role zero-extended for the display
    hex_digit_t player_digit;  // Seat zero-extended for the display

    // --------------------------------------------------
    // Control and deal datapath
    // --------------------------------------------------

    game_ctrl_if ctrl_bus ();

    game_controller game_controller_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .pass       (pass),
        .ctrl       (ctrl_bus.ctrl),
        .night_over (night_over)
    );

    deal_datapath deal_datapath_inst (
        .clock  (clock),
        .reset  (reset),
        .dp     (ctrl_bus.dp),
        .role   (role),
        .player (player)
    );

    // --------------------------------------------------
    // Displays
    // --------------------------------------------------

    assign role_digit   = hex_digit_t'(role);
    assign player_digit = hex_digit_t'(player);

    seg7_decoder role_display (
        .digit (role_digit),
        .seg   (role_seg)
    );

    seg7_decoder player_display (
        .digit (player_digit),
        .seg   (player_seg)
    );

endmodule

/* verif/lobinho_props.sv */
module lobinho_props (
    input logic clock,
    input logic reset,
    input logic shuffle,
    input logic next_player,
    input logic show_role,
    input logic night_over,
    input logic pass_pulse
);

    timeunit 1ns;
    timeprecision 100ps;

    // Deal spin and seat step belong to different states
    shuffle_excludes_step: assert property (@(posedge clock) disable iff (reset)
        !(shuffle && next_player))
        else $error("shuffle and next_player high in the same cycle");

    // Role stays hidden once the night is over
    hidden_after_night: assert property (@(posedge clock) disable iff (reset)
        night_over |-> !show_role)
        else $error("show_role high while night_over is high");

    // One press gives one pulse
    pulse_single_cycle: assert property (@(posedge clock) disable iff (reset)
        pass_pulse |=> !pass_pulse)
        else $error("pass pulse lasted two cycles");

endmodule

// Attached to every controller instance
bind game_controller lobinho_props lobinho_props_inst (
    .clock       (clock),
    .reset       (reset),
    .shuffle     (ctrl.shuffle),
    .next_player (ctrl.next_player),
    .show_role   (ctrl.show_role),
    .night_over  (night_over),
    .pass_pulse  (pass_pulse)
);

/* verif/lobinho_tb.sv */
`include "lobinho_params.svh"

module lobinho_tb import game_pkg::*, display_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int   NUM_PLAYERS = `LOB_NUM_PLAYERS;
    localparam int   WAIT_LIMIT  = 50;          // Cycles per wait
    localparam int   NUM_GAMES   = 4;
    localparam seg_t SEG_ZERO    = 7'b1000000;  // Digit 0 on the board
    localparam seg_t SEG_HIDDEN  = 7'b0110000;  // Digit 3, role code HIDDEN

    logic clock;
    logic reset;
    logic start;
    logic pass;
    seg_t role_seg;
    seg_t player_seg;
    logic night_over;

    lobinho_top lobinho_top_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .pass       (pass),
        .role_seg   (role_seg),
        .player_seg (player_seg),
        .night_over (night_over)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;  // 10 ns period
    end

    // --------------------------------------------------
    // Reporting and compare
    // --------------------------------------------------

    task automatic report_failure(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error at time %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_role(input role_t got, input role_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error at time %0t: %s is %s, expected %s",
                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_player(input player_t got, input player_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error at time %0t: %s is %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("error at time %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // --------------------------------------------------
    // Display decoding and deal rule
    // --------------------------------------------------

    // Board patterns back to digits, -1 if unknown
    function automatic int seg_to_digit(input seg_t s);
        case (s)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            default:    return -1;
        endcase
    endfunction

    task automatic read_role(output role_t r);
        int d;
        d = seg_to_digit(role_seg);
        if (d < 0) begin
            report_failure($sformatf("role display shows unknown pattern %b", role_seg));
        end
        r = role_t'(d[1:0]);
    endtask

    task automatic read_player(output player_t p);
        int d;
        d = seg_to_digit(player_seg);
        if (d < 0) begin
            report_failure($sformatf("player display shows unknown pattern %b", player_seg));
        end
        p = player_t'(d[2:0]);
    endtask

    // Row 4w+k: wolf at seat w, doctor the k-th other seat upward
    function automatic role_t rule_role(input int idx, input int seat);
        int wolf;
        int doctor;
        wolf = idx / 4;
        doctor = (idx % 4 < wolf) ? idx % 4 : idx % 4 + 1;
        if (seat == wolf) begin
            return WOLF;
        end
        if (seat == doctor) begin
            return DOCTOR;
        end
        return VILLAGER;
    endfunction

    task automatic check_deal(input role_t seen [NUM_PLAYERS]);
        int wolf;
        int doctor;
        int idx;
        wolf = -1;
        doctor = -1;
        foreach (seen[s]) begin
            if (seen[s] == WOLF) wolf = s;
            if (seen[s] == DOCTOR) doctor = s;
        end
        if (wolf < 0 || doctor < 0) begin
            report_failure("the dealt roles hold no wolf or no doctor");
        end
        idx = 4 * wolf + ((doctor < wolf) ? doctor : doctor - 1);  // Matching table row
        foreach (seen[s]) begin
            check_role(seen[s], rule_role(idx, s), $sformatf("role of player %0d", s));
        end
    endtask

    // --------------------------------------------------
    // Stimulus and waits
    // --------------------------------------------------

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        start <= 1'b0;
        pass  <= 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic press_pass(input int hold);
        @(posedge clock);
        pass <= 1'b1;
        repeat (hold) @(posedge clock);
        pass <= 1'b0;
        repeat (2) @(posedge clock);  // Low long enough for the next edge
    endtask

    task automatic press_start(input int hold);
        @(posedge clock);
        start <= 1'b1;
        repeat (hold) @(posedge clock);
        start <= 1'b0;
        repeat (2) @(posedge clock);
    endtask

    task automatic wait_role_visibility(input bit visible);
        bit done;
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            @(negedge clock);
            done = ((role_seg !== SEG_HIDDEN) == visible);
        end
        if (!done) begin
            report_failure(visible ? "timeout: the role never became visible"
                                   : "timeout: the role was never hidden again");
        end
    endtask

    task automatic wait_night_over();
        bit done;
        done = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !done; i++) begin
            @(negedge clock);
            done = (night_over === 1'b1);
        end
        if (!done) begin
            report_failure("timeout: night_over never went high after the last player");
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    task automatic check_reset_state();
        apply_reset();
        @(negedge clock);
        check_seg(role_seg, SEG_HIDDEN, "role_seg after reset");
        check_seg(player_seg, SEG_ZERO, "player_seg after reset");
        check_level(night_over, 1'b0, "night_over after reset");
    endtask

    // Start, let the deal counter spin, then freeze it
    task automatic start_game();
        press_start($urandom_range(1, 4));
        repeat ($urandom_range(1, 40)) @(posedge clock);
        press_pass($urandom_range(1, 6));
    endtask

    task automatic run_night(input bit long_hold);
        role_t   seen [NUM_PLAYERS];
        player_t shown;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            wait_role_visibility(1'b1);
            read_role(seen[p]);
            read_player(shown);
            check_player(shown, player_t'(p), "player on turn");
            if (long_hold && p == 1) begin
                press_pass(40);  // Held down, still one step
            end else begin
                press_pass($urandom_range(1, 6));
            end
            if (p < NUM_PLAYERS - 1) begin
                wait_role_visibility(1'b0);
                repeat (3) @(negedge clock);
                check_seg(role_seg, SEG_HIDDEN, "role_seg during handover");
                read_player(shown);
                check_player(shown, player_t'(p + 1), "player after pass");
                press_pass($urandom_range(1, 6));  // Next player looks
            end
        end
        wait_night_over();
        @(negedge clock);
        check_seg(role_seg, SEG_HIDDEN, "role_seg at night over");
        check_deal(seen);
    endtask

    // Night over holds against further presses
    task automatic check_night_locked();
        player_t shown;
        press_start($urandom_range(1, 4));
        press_pass($urandom_range(1, 6));
        repeat (5) @(negedge clock);
        check_level(night_over, 1'b1, "night_over after extra presses");
        check_seg(role_seg, SEG_HIDDEN, "role_seg after extra presses");
        read_player(shown);
        check_player(shown, player_t'(NUM_PLAYERS - 1), "player after extra presses");
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        pass  = 1'b0;
        void'($urandom(12));
        check_reset_state();
        start_game();
        run_night(1'b1);
        check_night_locked();
        // More games, other shuffle lengths
        for (int g = 1; g < NUM_GAMES; g++) begin
            check_reset_state();
            start_game();
            run_night(1'b0);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

/* lobinho_top.f */
+incdir+common
common/game_pkg.sv
common/display_pkg.sv
common/game_ctrl_if.sv
logic/mod_counter.sv
logic/seg7_decoder.sv
deal/deal_rom.sv
deal/deal_datapath.sv
game_controller/game_controller.sv
logic/lobinho_top.sv
verif/lobinho_props.sv
verif/lobinho_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the lobinho testbench with Verilator, status follows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lobinho_tb -f lobinho_top.f -o lobinho_sim \
    && ./obj_dir/lobinho_sim 2>&1 | tee /dev/stderr | grep -F '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
